// File: Makefile
# Verilator build and run of the track matching testbench

VERILATOR ?= verilator
TOP       ?= tb_track_match
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
verilog/track_pkg.sv
verilog/vmproj_if.sv
verilog/vmproj_memory.sv
verilog/projection_router.sv
verilog/match_engine.sv
verilog/track_match_top.sv
sim/match_checker.sv
sim/tb_track_match.sv

// File: sim/match_checker.sv
`timescale 1ns/100ps

module match_checker (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start,
  input  logic [track_pkg::BX_W-1:0]             bx,
  input  logic                                   busy,
  input  logic                                   proj_rd_en,
  input  logic                                   stub_rd_en,
  input  logic                                   cand_valid,
  input  track_pkg::cand_t                       cand,
  input  logic [track_pkg::BX_W-1:0]             cand_bx,
  input  logic                                   done,
  input  track_pkg::proj_t [1:0][track_pkg::NUM_PROJ_IN-1:0][2**track_pkg::ADDR_W-1:0] proj_mem,
  input  logic [track_pkg::NUM_PROJ_IN-1:0][track_pkg::NENT_W-1:0] proj_nentries,
  input  track_pkg::stub_t [1:0][track_pkg::NUM_VM-1:0][2**track_pkg::ADDR_W-1:0] stub_mem,
  input  logic [1:0][track_pkg::NUM_VM-1:0][track_pkg::NENT_W-1:0] stub_nentries,
  output int                                     tests_done,
  output int                                     tests_failed,
  output int                                     errors
);

  localparam int REC_W = track_pkg::BX_W + $bits(track_pkg::cand_t);

  // Expected {bx, cand} records of all open events with the oldest first
  logic [REC_W-1:0]           exp_q[$];
  int                         exp_n_q[$];
  logic [track_pkg::BX_W-1:0] bx_q[$];
  bit                         started;
  int                         got_n;
  int                         ev_err;

  function automatic bit in_window(input logic [2:0] pz, input logic [2:0] pb,
                                   input logic [2:0] sz, input logic [2:0] sb);
    int dz;
    int db;
    dz = int'(sz) - int'(pz);
    db = int'(sb) - int'(pb);
    if (db < 0) begin
      db = -db;
    end
    return (dz == 0 || dz == 1) && db <= track_pkg::BEND_WINDOW;
  endfunction

  // Bin ascending, projections in write order, stubs ascending
  task automatic build_expected(input logic [track_pkg::BX_W-1:0] ev_bx);
    track_pkg::proj_t p;
    track_pkg::stub_t s;
    track_pkg::cand_t c;
    logic             pg;
    int               n;
    pg = ev_bx[0];
    n  = 0;
    for (int vm = 0; vm < track_pkg::NUM_VM; vm++) begin
      for (int src = 0; src < track_pkg::NUM_PROJ_IN; src++) begin
        for (int a = 0; a < int'(proj_nentries[src]); a++) begin
          p = proj_mem[pg][src][a];
          if (int'(p.phi[track_pkg::PHI_W-1 -: track_pkg::VM_W]) == vm) begin
            for (int sa = 0; sa < int'(stub_nentries[pg][vm]); sa++) begin
              s = stub_mem[pg][vm][sa];
              if (in_window(p.z[track_pkg::Z_W-1 -: track_pkg::ZBIN_W], p.bend,
                            s.zbin, s.bend)) begin
                c.tidx      = p.tidx;
                c.vm        = vm[track_pkg::VM_W-1:0];
                c.stub_addr = sa[track_pkg::ADDR_W-1:0];
                exp_q.push_back({ev_bx, c});
                n++;
              end
            end
          end
        end
      end
    end
    exp_n_q.push_back(n);
  endtask

  task automatic value_error(input string msg);
    $display("** Error @ %0t: %s", $time, msg);
    errors++;
    ev_err++;
  endtask

  task automatic check_cand();
    logic [REC_W-1:0] want;
    track_pkg::cand_t want_c;
    got_n++;
    if (exp_q.size() == 0) begin
      $display("Candidate at %0t arrived when no candidate was expected", $time);
      errors++;
      ev_err++;
    end else begin
      want   = exp_q.pop_front();
      want_c = want[$bits(track_pkg::cand_t)-1:0];
      if ({cand_bx, cand} !== want) begin
        value_error($sformatf("cand bx %0d tidx %0d vm %0d stub %0d, expected %0d %0d %0d %0d",
                              cand_bx, cand.tidx, cand.vm, cand.stub_addr,
                              want[REC_W-1 -: track_pkg::BX_W], want_c.tidx, want_c.vm,
                              want_c.stub_addr));
      end
    end
  endtask

  task automatic finish_event();
    logic [track_pkg::BX_W-1:0] want_bx;
    int                         want_n;
    if (bx_q.size() == 0) begin
      $display("done pulsed at %0t with no start outstanding", $time);
      errors++;
    end else begin
      want_bx = bx_q.pop_front();
      want_n  = exp_n_q.pop_front();
      if (cand_bx !== want_bx) begin
        value_error($sformatf("done for bx %0d, expected bx %0d", cand_bx, want_bx));
      end
      if (got_n != want_n) begin
        value_error($sformatf("bx %0d gave %0d candidates, expected %0d", want_bx, got_n, want_n));
      end
      // Drop what this bx still owed so the next one lines up
      for (int i = got_n; i < want_n; i++) begin
        if (exp_q.size() > 0) begin
          exp_q.delete(0);
        end
      end
      tests_done++;
      if (ev_err != 0) begin
        tests_failed++;
      end
      $display("test %0d bx %0d: %0d of %0d candidates, %s", tests_done, want_bx, got_n,
               want_n, (ev_err == 0) ? "ok" : "mismatch");
    end
    got_n  = 0;
    ev_err = 0;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      started = 1'b0;
    end else begin
      if (!started && (done || cand_valid || busy || proj_rd_en || stub_rd_en)) begin
        $display("Output active at %0t before the first start", $time);
        errors++;
      end
      if (start && !busy) begin
        started = 1'b1;
        bx_q.push_back(bx);
        build_expected(bx);
      end
      if (cand_valid) begin
        check_cand();
      end
      if (done) begin
        finish_event();
      end
    end
  end

endmodule

// File: sim/tb_track_match.sv
`timescale 1ns/100ps

module tb_track_match;

  localparam int NUM_EVENTS      = 40;
  localparam int WORST_EVENT     = 2 * (2 * 63) + 4 * 63 * 64;
  localparam int WATCHDOG_CYCLES = NUM_EVENTS * WORST_EVENT + 2000;
  localparam int DEPTH           = 2**track_pkg::ADDR_W;
  localparam logic [31:0] SEED   = 32'hf0c5_7cda;

  logic                             clk;
  logic                             rst_n;
  logic                             start;
  logic [track_pkg::BX_W-1:0]       bx;
  logic                             proj_rd_en;
  logic [track_pkg::SEL_W-1:0]      proj_rd_sel;
  logic [track_pkg::ADDR_W-1:0]     proj_rd_addr;
  logic                             proj_rd_page;
  track_pkg::proj_t                 proj_data;
  logic [track_pkg::NUM_PROJ_IN-1:0][track_pkg::NENT_W-1:0] proj_nentries;
  logic                             stub_rd_en;
  logic [track_pkg::VM_W-1:0]       stub_rd_vm;
  logic [track_pkg::ADDR_W-1:0]     stub_rd_addr;
  logic                             stub_rd_page;
  track_pkg::stub_t                 stub_data;
  logic [1:0][track_pkg::NUM_VM-1:0][track_pkg::NENT_W-1:0] stub_nentries;
  logic                             cand_valid;
  track_pkg::cand_t                 cand;
  logic [track_pkg::BX_W-1:0]       cand_bx;
  logic                             done;
  logic                             busy;

  // Paged input memories indexed by bx bit 0
  track_pkg::proj_t [1:0][track_pkg::NUM_PROJ_IN-1:0][DEPTH-1:0] proj_mem;
  track_pkg::stub_t [1:0][track_pkg::NUM_VM-1:0][DEPTH-1:0]      stub_mem;

  logic [31:0] lfsr;
  int          tests_done;
  int          tests_failed;
  int          errors;

  always #10 clk = ~clk;

  // Both memories answer one cycle after the read enable
  always @(posedge clk) begin
    if (proj_rd_en) begin
      proj_data <= proj_mem[proj_rd_page][proj_rd_sel][proj_rd_addr];
    end
    if (stub_rd_en) begin
      stub_data <= stub_mem[stub_rd_page][stub_rd_vm][stub_rd_addr];
    end
  end

  track_match_top u_track_match_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .bx            (bx),
    .proj_rd_en    (proj_rd_en),
    .proj_rd_sel   (proj_rd_sel),
    .proj_rd_addr  (proj_rd_addr),
    .proj_rd_page  (proj_rd_page),
    .proj_data     (proj_data),
    .proj_nentries (proj_nentries),
    .stub_rd_en    (stub_rd_en),
    .stub_rd_vm    (stub_rd_vm),
    .stub_rd_addr  (stub_rd_addr),
    .stub_rd_page  (stub_rd_page),
    .stub_data     (stub_data),
    .stub_nentries (stub_nentries),
    .cand_valid    (cand_valid),
    .cand          (cand),
    .cand_bx       (cand_bx),
    .done          (done),
    .busy          (busy)
  );

  match_checker u_match_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .bx            (bx),
    .busy          (busy),
    .proj_rd_en    (proj_rd_en),
    .stub_rd_en    (stub_rd_en),
    .cand_valid    (cand_valid),
    .cand          (cand),
    .cand_bx       (cand_bx),
    .done          (done),
    .proj_mem      (proj_mem),
    .proj_nentries (proj_nentries),
    .stub_mem      (stub_mem),
    .stub_nentries (stub_nentries),
    .tests_done    (tests_done),
    .tests_failed  (tests_failed),
    .errors        (errors)
  );

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // Loads the page of event ev and leaves inputs or stubs empty in some events
  task automatic fill_event(input int ev);
    logic [31:0] r;
    logic        pg;
    pg = ev[0];
    for (int i = 0; i < track_pkg::NUM_PROJ_IN; i++) begin
      take_bits(4, r);
      proj_nentries[i] = (ev % 10 == 3) ? '0 : r[track_pkg::NENT_W-1:0];
      for (int a = 0; a < int'(proj_nentries[i]); a++) begin
        take_bits($bits(track_pkg::proj_t), r);
        proj_mem[pg][i][a] = track_pkg::proj_t'(r[$bits(track_pkg::proj_t)-1:0]);
      end
    end
    for (int v = 0; v < track_pkg::NUM_VM; v++) begin
      take_bits(4, r);
      stub_nentries[pg][v] = (ev % 10 == 6) ? '0 : r[track_pkg::NENT_W-1:0];
      for (int a = 0; a < int'(stub_nentries[pg][v]); a++) begin
        take_bits($bits(track_pkg::stub_t), r);
        stub_mem[pg][v][a] = track_pkg::stub_t'(r[$bits(track_pkg::stub_t)-1:0]);
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    start         = 1'b0;
    bx            = '0;
    proj_data     = '0;
    stub_data     = '0;
    proj_nentries = '0;
    stub_nentries = '0;
    proj_mem      = '0;
    stub_mem      = '0;
    lfsr          = SEED;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // Quiet period before the first start
    repeat (8) @(negedge clk);
    for (int ev = 0; ev < NUM_EVENTS; ev++) begin
      while (busy) @(negedge clk);
      fill_event(ev);
      bx    = ev[track_pkg::BX_W-1:0];
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (tests_done < NUM_EVENTS) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("tests %0d, failing tests %0d, errors %0d", tests_done, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, %0d of %0d tests finished",
             WATCHDOG_CYCLES, tests_done, NUM_EVENTS);
    $display("sim failed");
    $finish;
  end

endmodule

// File: verilog/match_engine.sv
`timescale 1ns/100ps

module match_engine (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   handoff,
  input  logic [track_pkg::BX_W-1:0]             handoff_bx,
  output logic                                   ready,
  vmproj_if.reader                               vm_rd,
  output logic                                   stub_rd_en,
  output logic [track_pkg::VM_W-1:0]             stub_rd_vm,
  output logic [track_pkg::ADDR_W-1:0]           stub_rd_addr,
  output logic                                   stub_rd_page,
  input  track_pkg::stub_t                       stub_data,
  input  logic [1:0][track_pkg::NUM_VM-1:0][track_pkg::NENT_W-1:0] stub_nentries,
  output logic                                   cand_valid,
  output track_pkg::cand_t                       cand,
  output logic [track_pkg::BX_W-1:0]             cand_bx,
  output logic                                   done
);

  track_pkg::engine_state_t     state;
  logic                         pend_valid;
  logic [track_pkg::BX_W-1:0]   pend_bx;
  logic [track_pkg::BX_W-1:0]   bx_q;
  logic [track_pkg::VM_W-1:0]   vm_q;
  logic [track_pkg::ADDR_W-1:0] proj_addr;
  logic [track_pkg::ADDR_W-1:0] stub_addr;
  track_pkg::vmproj_t           proj_q;
  logic [track_pkg::NENT_W-1:0] nstub;
  logic                         bin_done;
  logic                         last_vm;
  logic                         s1_valid;
  logic [track_pkg::VM_W-1:0]   s1_vm;
  logic [track_pkg::ADDR_W-1:0] s1_addr;
  logic [track_pkg::BEND_W-1:0] bend_diff;
  logic                         z_ok;
  logic                         bend_ok;

  assign ready    = !pend_valid;
  assign nstub    = stub_nentries[bx_q[0]][vm_q];
  assign bin_done = (proj_addr == vm_rd.nentries[vm_q]) || (nstub == '0);
  assign last_vm  = (int'(vm_q) == track_pkg::NUM_VM - 1);

  assign vm_rd.rd_en   = (state == track_pkg::E_NEXT_VM) && !bin_done;
  assign vm_rd.rd_page = bx_q[0];
  assign vm_rd.rd_vm   = vm_q;
  assign vm_rd.rd_addr = proj_addr;
  assign stub_rd_en    = (state == track_pkg::E_SCAN_STUB);
  assign stub_rd_vm    = vm_q;
  assign stub_rd_addr  = stub_addr;
  assign stub_rd_page  = bx_q[0];

  // One bx waiting behind the one being matched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
      pend_bx    <= '0;
    end else if (handoff) begin
      pend_valid <= 1'b1;
      pend_bx    <= handoff_bx;
    end else if (state == track_pkg::E_IDLE) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= track_pkg::E_IDLE;
      bx_q      <= '0;
      vm_q      <= '0;
      proj_addr <= '0;
      stub_addr <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        track_pkg::E_IDLE: begin
          if (pend_valid) begin
            bx_q      <= pend_bx;
            vm_q      <= '0;
            proj_addr <= '0;
            state     <= track_pkg::E_NEXT_VM;
          end
        end
        track_pkg::E_NEXT_VM: begin
          if (!bin_done) begin
            state <= track_pkg::E_LOAD_PROJ;
          end else if (!last_vm) begin
            vm_q      <= vm_q + 1'b1;
            proj_addr <= '0;
          end else if (!s1_valid) begin
            // Last compare has left the pipe
            done  <= 1'b1;
            state <= track_pkg::E_IDLE;
          end
        end
        track_pkg::E_LOAD_PROJ: begin
          stub_addr <= '0;
          state     <= track_pkg::E_SCAN_STUB;
        end
        default: begin
          if (stub_addr == nstub - 1'b1) begin
            proj_addr <= proj_addr + 1'b1;
            state     <= track_pkg::E_NEXT_VM;
          end else begin
            stub_addr <= stub_addr + 1'b1;
          end
        end
      endcase
    end
  end

  // Window check on the returned stub
  assign z_ok = (stub_data.zbin == proj_q.zbin) ||
                ({1'b0, stub_data.zbin} == {1'b0, proj_q.zbin} + 1'b1);
  assign bend_diff = (stub_data.bend > proj_q.bend) ? stub_data.bend - proj_q.bend
                                                    : proj_q.bend - stub_data.bend;
  assign bend_ok = (int'(bend_diff) <= track_pkg::BEND_WINDOW);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      cand_valid <= 1'b0;
    end else begin
      s1_valid   <= stub_rd_en;
      cand_valid <= s1_valid && z_ok && bend_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (state == track_pkg::E_LOAD_PROJ) begin
      proj_q <= vm_rd.rd_data;
    end
    s1_vm          <= vm_q;
    s1_addr        <= stub_addr;
    cand.tidx      <= proj_q.tidx;
    cand.vm        <= s1_vm;
    cand.stub_addr <= s1_addr;
    cand_bx        <= bx_q;
  end

  // Router waits on ready, so a second handoff never stacks up
  a_single_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    handoff |-> !pend_valid
  );

endmodule

// File: verilog/projection_router.sv
`timescale 1ns/100ps

module projection_router (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                start,
  input  logic [track_pkg::BX_W-1:0]                          bx,
  output logic                                                ready,
  output logic                                                proj_rd_en,
  output logic [track_pkg::SEL_W-1:0]                         proj_rd_sel,
  output logic [track_pkg::ADDR_W-1:0]                        proj_rd_addr,
  output logic                                                proj_rd_page,
  input  track_pkg::proj_t                                    proj_data,
  input  logic [track_pkg::NUM_PROJ_IN-1:0][track_pkg::NENT_W-1:0] proj_nentries,
  vmproj_if.writer                                            vm_wr,
  output logic                                                handoff,
  output logic [track_pkg::BX_W-1:0]                          handoff_bx
);

  track_pkg::router_state_t     state;
  logic [track_pkg::BX_W-1:0]   bx_q;
  logic [track_pkg::SEL_W-1:0]  sel_q;
  logic [track_pkg::ADDR_W-1:0] addr_q;
  logic                         clear_q;
  logic                         rd_v1;
  logic                         next_found;
  logic [track_pkg::SEL_W-1:0]  next_sel;
  logic                         last_entry;

  // Lowest non-empty input after the current one
  always_comb begin
    int lo;
    lo = (state == track_pkg::R_IDLE) ? 0 : int'(sel_q) + 1;
    next_found = 1'b0;
    next_sel   = '0;
    for (int i = track_pkg::NUM_PROJ_IN - 1; i >= 0; i--) begin
      if (i >= lo && proj_nentries[i] != '0) begin
        next_found = 1'b1;
        next_sel   = i[track_pkg::SEL_W-1:0];
      end
    end
  end

  assign last_entry = (addr_q == proj_nentries[sel_q] - 1'b1);

  assign ready            = (state == track_pkg::R_IDLE);
  assign proj_rd_en       = (state == track_pkg::R_READ);
  assign proj_rd_sel      = sel_q;
  assign proj_rd_addr     = addr_q;
  assign proj_rd_page     = bx_q[0];
  assign handoff          = (state == track_pkg::R_DONE);
  assign handoff_bx       = bx_q;
  assign vm_wr.clear      = clear_q;
  assign vm_wr.clear_page = bx_q[0];
  assign vm_wr.wr_page    = bx_q[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= track_pkg::R_IDLE;
      bx_q    <= '0;
      sel_q   <= '0;
      addr_q  <= '0;
      clear_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (state)
        track_pkg::R_IDLE: begin
          if (start) begin
            bx_q    <= bx;
            clear_q <= 1'b1;
            sel_q   <= next_sel;
            addr_q  <= '0;
            state   <= next_found ? track_pkg::R_READ : track_pkg::R_DRAIN;
          end
        end
        track_pkg::R_READ: begin
          if (!last_entry) begin
            addr_q <= addr_q + 1'b1;
          end else if (next_found) begin
            sel_q  <= next_sel;
            addr_q <= '0;
          end else begin
            state <= track_pkg::R_DRAIN;
          end
        end
        track_pkg::R_DRAIN: begin
          if (!rd_v1) begin
            state <= track_pkg::R_DONE;
          end
        end
        default: state <= track_pkg::R_IDLE;
      endcase
    end
  end

  // Read data stage, then write stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_v1    <= 1'b0;
      vm_wr.we <= 1'b0;
    end else begin
      rd_v1    <= proj_rd_en;
      vm_wr.we <= rd_v1;
    end
  end

  // Bin from top phi bits, z bin from top z bits
  always_ff @(posedge clk) begin
    if (rd_v1) begin
      vm_wr.wr_vm        <= proj_data.phi[track_pkg::PHI_W-1 -: track_pkg::VM_W];
      vm_wr.wr_data.tidx <= proj_data.tidx;
      vm_wr.wr_data.zbin <= proj_data.z[track_pkg::Z_W-1 -: track_pkg::ZBIN_W];
      vm_wr.wr_data.bend <= proj_data.bend;
    end
  end

  // Engine may only see the page after its last write
  a_handoff_no_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    handoff |-> !vm_wr.we && !rd_v1
  );

endmodule

// File: verilog/track_match_top.sv
`timescale 1ns/100ps

module track_match_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start,
  input  logic [track_pkg::BX_W-1:0]             bx,
  output logic                                   proj_rd_en,
  output logic [track_pkg::SEL_W-1:0]            proj_rd_sel,
  output logic [track_pkg::ADDR_W-1:0]           proj_rd_addr,
  output logic                                   proj_rd_page,
  input  track_pkg::proj_t                       proj_data,
  input  logic [track_pkg::NUM_PROJ_IN-1:0][track_pkg::NENT_W-1:0] proj_nentries,
  output logic                                   stub_rd_en,
  output logic [track_pkg::VM_W-1:0]             stub_rd_vm,
  output logic [track_pkg::ADDR_W-1:0]           stub_rd_addr,
  output logic                                   stub_rd_page,
  input  track_pkg::stub_t                       stub_data,
  input  logic [1:0][track_pkg::NUM_VM-1:0][track_pkg::NENT_W-1:0] stub_nentries,
  output logic                                   cand_valid,
  output track_pkg::cand_t                       cand,
  output logic [track_pkg::BX_W-1:0]             cand_bx,
  output logic                                   done,
  output logic                                   busy
);

  logic                       router_start;
  logic                       router_ready;
  logic                       engine_ready;
  logic                       handoff;
  logic [track_pkg::BX_W-1:0] handoff_bx;

  vmproj_if u_vmproj_if ();

  assign busy = !(router_ready && engine_ready);

  // Start only counts while nothing is queued
  assign router_start = start && !busy;

  vmproj_memory u_vmproj_memory (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (u_vmproj_if)
  );

  projection_router u_projection_router (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (router_start),
    .bx            (bx),
    .ready         (router_ready),
    .proj_rd_en    (proj_rd_en),
    .proj_rd_sel   (proj_rd_sel),
    .proj_rd_addr  (proj_rd_addr),
    .proj_rd_page  (proj_rd_page),
    .proj_data     (proj_data),
    .proj_nentries (proj_nentries),
    .vm_wr         (u_vmproj_if),
    .handoff       (handoff),
    .handoff_bx    (handoff_bx)
  );

  match_engine u_match_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .handoff       (handoff),
    .handoff_bx    (handoff_bx),
    .ready         (engine_ready),
    .vm_rd         (u_vmproj_if),
    .stub_rd_en    (stub_rd_en),
    .stub_rd_vm    (stub_rd_vm),
    .stub_rd_addr  (stub_rd_addr),
    .stub_rd_page  (stub_rd_page),
    .stub_data     (stub_data),
    .stub_nentries (stub_nentries),
    .cand_valid    (cand_valid),
    .cand          (cand),
    .cand_bx       (cand_bx),
    .done          (done)
  );

endmodule

// File: verilog/track_pkg.sv
package track_pkg;

  localparam int NUM_PROJ_IN = 2;
  localparam int SEL_W       = $clog2(NUM_PROJ_IN);
  localparam int NUM_VM      = 4;
  localparam int VM_W        = 2;
  localparam int NENT_W      = 6;
  localparam int ADDR_W      = 6;
  localparam int BX_W        = 3;

  // Field widths
  localparam int TIDX_W = 7;
  localparam int PHI_W  = 8;
  localparam int Z_W    = 7;
  localparam int ZBIN_W = 3;
  localparam int BEND_W = 3;

  // Largest bend difference still accepted
  localparam int BEND_WINDOW = 1;

  typedef struct packed {
    logic [TIDX_W-1:0] tidx;
    logic [PHI_W-1:0]  phi;
    logic [Z_W-1:0]    z;
    logic [BEND_W-1:0] bend;
  } proj_t;

  typedef struct packed {
    logic [TIDX_W-1:0] tidx;
    logic [ZBIN_W-1:0] zbin;
    logic [BEND_W-1:0] bend;
  } vmproj_t;

  typedef struct packed {
    logic [ZBIN_W-1:0] zbin;
    logic [BEND_W-1:0] bend;
  } stub_t;

  typedef struct packed {
    logic [TIDX_W-1:0] tidx;
    logic [VM_W-1:0]   vm;
    logic [ADDR_W-1:0] stub_addr;
  } cand_t;

  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_DRAIN,
    R_DONE
  } router_state_t;

  typedef enum logic [1:0] {
    E_IDLE,
    E_LOAD_PROJ,
    E_SCAN_STUB,
    E_NEXT_VM
  } engine_state_t;

endpackage

// File: verilog/vmproj_if.sv
`timescale 1ns/100ps

interface vmproj_if;

  // Write side
  logic                         clear;
  logic                         clear_page;
  logic                         we;
  logic                         wr_page;
  logic [track_pkg::VM_W-1:0]   wr_vm;
  track_pkg::vmproj_t           wr_data;

  // Read side
  logic                         rd_en;
  logic                         rd_page;
  logic [track_pkg::VM_W-1:0]   rd_vm;
  logic [track_pkg::ADDR_W-1:0] rd_addr;
  track_pkg::vmproj_t           rd_data;
  logic [track_pkg::NUM_VM-1:0][track_pkg::NENT_W-1:0] nentries;

  modport writer (
    output clear, clear_page, we, wr_page, wr_vm, wr_data
  );

  modport reader (
    output rd_en, rd_page, rd_vm, rd_addr,
    input  rd_data, nentries
  );

  modport memory (
    input  clear, clear_page, we, wr_page, wr_vm, wr_data,
    input  rd_en, rd_page, rd_vm, rd_addr,
    output rd_data, nentries
  );

endinterface

// File: verilog/vmproj_memory.sv
`timescale 1ns/100ps

module vmproj_memory (
  input  logic     clk,
  input  logic     rst_n,
  vmproj_if.memory mem
);

  track_pkg::vmproj_t ram [2][track_pkg::NUM_VM][2**track_pkg::ADDR_W];
  logic [track_pkg::NENT_W-1:0] count [2][track_pkg::NUM_VM];

  // Fill level per page and bin also serves as the write address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < 2; p++) begin
        for (int v = 0; v < track_pkg::NUM_VM; v++) begin
          count[p][v] <= '0;
        end
      end
    end else begin
      if (mem.clear) begin
        for (int v = 0; v < track_pkg::NUM_VM; v++) begin
          count[mem.clear_page][v] <= '0;
        end
      end
      if (mem.we) begin
        count[mem.wr_page][mem.wr_vm] <= count[mem.wr_page][mem.wr_vm] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem.we) begin
      ram[mem.wr_page][mem.wr_vm][count[mem.wr_page][mem.wr_vm]] <= mem.wr_data;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      mem.rd_data <= ram[mem.rd_page][mem.rd_vm][mem.rd_addr];
    end
  end

  // Counts of the page being read
  for (genvar v = 0; v < track_pkg::NUM_VM; v++) begin : g_nent
    assign mem.nentries[v] = count[mem.rd_page][v];
  end

  // Router must never push into a bin already at 63
  a_no_full_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem.we |-> !(&count[mem.wr_page][mem.wr_vm])
  );

endmodule
